// File: design/memPkg.sv
`default_nettype none

package memPkg;

    // word width of the data path, lane count follows from it
    localparam int dataWidth = 32;
    localparam int laneCount = dataWidth / 8;

    // load kinds, U means zero extension
    typedef enum logic [2:0] {
        ldNone,
        ldByte,
        ldByteU,
        ldHalf,
        ldHalfU,
        ldWord
    } loadType;

    typedef enum logic [1:0] {
        stNone,
        stByte,
        stHalf,
        stWord
    } storeType;

    // MIPS cause register ExcCode values
    typedef enum logic [4:0] {
        excNone = 5'd0,
        excAdEL = 5'd4,   // address error on load
        excAdES = 5'd5,   // address error on store
        excDBE  = 5'd7    // bus error on data access
    } excCode;

endpackage

`default_nettype wire

// File: design/memStageReg.sv
`timescale 1ns/1ps
`default_nettype none

module memStageReg (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         memFlush,
    input  logic                         exeValid,
    output logic                         exeReady,
    input  logic                         retire,
    input  logic [memPkg::dataWidth-1:0] exeAluOut,
    input  logic [memPkg::dataWidth-1:0] exeStoreData,
    input  memPkg::loadType              exeLoadType,
    input  memPkg::storeType             exeStoreType,
    input  logic [4:0]                   exeDst,
    input  logic                         exeRegWr,
    output logic                         heldValid,
    output logic [memPkg::dataWidth-1:0] heldAddr,
    output logic [memPkg::dataWidth-1:0] heldStoreData,
    output memPkg::loadType              heldLoadType,
    output memPkg::storeType             heldStoreType,
    output logic [4:0]                   heldDst,
    output logic                         heldRegWr
);
    logic busy;         // held op is still on the bus
    logic accept;
    logic flushPend;    // flush seen mid-transfer, waits for completion
    logic applyFlush;

    // anything held and not retiring this cycle is an APB transfer in flight
    assign busy       = heldValid && !retire;
    assign exeReady   = !heldValid || retire;
    assign accept     = exeValid && exeReady;
    assign applyFlush = (memFlush || flushPend) && !busy;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            heldValid <= 1'b0;
            flushPend <= 1'b0;
        end else begin
            flushPend <= busy && (memFlush || flushPend);
            if (applyFlush) begin
                heldValid <= 1'b0;      // drops the incoming op as well
            end else if (accept) begin
                heldValid <= 1'b1;
            end else if (retire) begin
                heldValid <= 1'b0;
            end
        end
    end

    // instruction fields
    always_ff @(posedge clk) begin
        if (accept) begin
            heldAddr      <= exeAluOut;
            heldStoreData <= exeStoreData;
            heldLoadType  <= exeLoadType;
            heldStoreType <= exeStoreType;
            heldDst       <= exeDst;
            heldRegWr     <= exeRegWr;
        end
    end

endmodule

`default_nettype wire

// File: design/storeLane.sv
`timescale 1ns/1ps
`default_nettype none

module storeLane #(
    parameter int laneIndex = 0
) (
    input  memPkg::storeType             heldStoreType,
    input  logic [1:0]                   addrLow,
    input  logic [memPkg::dataWidth-1:0] storeData,
    output logic                         laneStrb,
    output logic [7:0]                   laneByte
);
    localparam logic [1:0] lanePos = 2'(laneIndex);

    always_comb begin
        laneStrb = 1'b0;
        laneByte = storeData[8*laneIndex +: 8];     // own byte for words
        case (heldStoreType)
            memPkg::stByte: begin
                laneStrb = (addrLow == lanePos);
                laneByte = storeData[7:0];
            end
            memPkg::stHalf: begin
                laneStrb = (addrLow[1] == lanePos[1]);
                // low lane of the pair takes the low byte of the half
                laneByte = lanePos[0] ? storeData[15:8] : storeData[7:0];
            end
            memPkg::stWord: laneStrb = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: design/memAccessCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module memAccessCtrl #(
    parameter int apbAddrWidth = 16
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         heldValid,
    input  logic [memPkg::dataWidth-1:0] heldAddr,
    input  memPkg::loadType              heldLoadType,
    input  memPkg::storeType             heldStoreType,
    input  logic [4:0]                   heldDst,
    input  logic                         heldRegWr,
    input  logic [memPkg::laneCount-1:0] laneStrb,
    input  logic [memPkg::dataWidth-1:0] laneData,
    output logic                         retire,
    output logic                         memValid,
    output logic [memPkg::dataWidth-1:0] memResult,
    output logic [4:0]                   memDst,
    output logic                         memRegWr,
    output memPkg::excCode               memExc,
    output logic [memPkg::dataWidth-1:0] memBadVAddr,
    output logic [apbAddrWidth-1:0]      paddr,
    output logic                         psel,
    output logic                         penable,
    output logic                         pwrite,
    output logic [memPkg::dataWidth-1:0] pwdata,
    output logic [memPkg::laneCount-1:0] pstrb,
    input  logic [memPkg::dataWidth-1:0] prdata,
    input  logic                         pready,
    input  logic                         pslverr
);
    typedef enum logic [1:0] {
        apbIdle,
        apbSetup,
        apbAccess
    } apbState;

    apbState                      state;
    apbState                      phase;      // bus phase seen this cycle
    apbState                      nextState;
    logic                         isLoad;
    logic                         isStore;
    logic                         misaligned;
    logic                         addrErr;
    logic                         startReq;
    logic                         doneReg;    // bus access finished last edge
    logic                         busErr;
    logic [7:0]                   loadByte;
    logic [15:0]                  loadHalf;
    logic [memPkg::dataWidth-1:0] loadData;
    logic [memPkg::dataWidth-1:0] resultReg;

    assign isLoad  = heldLoadType != memPkg::ldNone;
    assign isStore = heldStoreType != memPkg::stNone;

    // half needs bit 0 clear, word needs bits 1:0 clear
    always_comb begin
        misaligned = 1'b0;
        case (heldLoadType)
            memPkg::ldHalf, memPkg::ldHalfU: misaligned = heldAddr[0];
            memPkg::ldWord:                  misaligned = |heldAddr[1:0];
            default: ;
        endcase
        case (heldStoreType)
            memPkg::stHalf: misaligned = heldAddr[0];
            memPkg::stWord: misaligned = |heldAddr[1:0];
            default: ;
        endcase
    end

    assign addrErr  = misaligned && (isLoad || isStore);
    assign startReq = heldValid && (isLoad || isStore) && !addrErr && !doneReg;

    // setup comes straight out of idle, so the bus starts the cycle after capture
    always_comb begin
        phase = state;
        if (state == apbIdle && startReq) begin
            phase = apbSetup;
        end
    end

    always_comb begin
        case (phase)
            apbSetup:  nextState = apbAccess;
            apbAccess: nextState = pready ? apbIdle : apbAccess;
            default:   nextState = apbIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= apbIdle;
            doneReg <= 1'b0;
        end else begin
            state   <= nextState;
            doneReg <= (phase == apbAccess) && pready;
        end
    end

    // pick the addressed byte or half, then extend
    always_comb begin
        loadByte = prdata[8*heldAddr[1:0] +: 8];
        loadHalf = prdata[16*heldAddr[1] +: 16];
        case (heldLoadType)
            memPkg::ldByte:  loadData = {{(memPkg::dataWidth-8){loadByte[7]}}, loadByte};
            memPkg::ldByteU: loadData = {{(memPkg::dataWidth-8){1'b0}}, loadByte};
            memPkg::ldHalf:  loadData = {{(memPkg::dataWidth-16){loadHalf[15]}}, loadHalf};
            memPkg::ldHalfU: loadData = {{(memPkg::dataWidth-16){1'b0}}, loadHalf};
            default:         loadData = prdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (phase == apbAccess && pready) begin
            resultReg <= isLoad ? loadData : heldAddr;
            busErr    <= pslverr;
        end
    end

    assign paddr   = apbAddrWidth'({heldAddr[memPkg::dataWidth-1:2], 2'b00});
    assign psel    = phase != apbIdle;
    assign penable = phase == apbAccess;
    assign pwrite  = isStore;
    assign pwdata  = laneData;
    assign pstrb   = isStore ? laneStrb : '0;   // reads carry no strobes

    // non-memory ops and address errors retire straight from the held register
    assign memValid  = (heldValid && (!(isLoad || isStore) || addrErr)) || doneReg;
    assign retire    = memValid;
    assign memResult = doneReg ? resultReg : heldAddr;
    assign memDst    = heldDst;
    assign memRegWr  = heldRegWr && !addrErr && !(doneReg && busErr);

    always_comb begin
        memExc      = memPkg::excNone;
        memBadVAddr = '0;
        if (addrErr) begin
            memExc      = isLoad ? memPkg::excAdEL : memPkg::excAdES;
            memBadVAddr = heldAddr;
        end else if (doneReg && busErr) begin
            memExc = memPkg::excDBE;
        end
    end

endmodule

`default_nettype wire

// File: design/memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage #(
    parameter int apbAddrWidth = 16
) (
    input  logic                         clk,
    input  logic                         rstN,
    // from execute
    input  logic                         exeValid,
    output logic                         exeReady,
    input  logic [memPkg::dataWidth-1:0] exeAluOut,
    input  logic [memPkg::dataWidth-1:0] exeStoreData,
    input  memPkg::loadType              exeLoadType,
    input  memPkg::storeType             exeStoreType,
    input  logic [4:0]                   exeDst,
    input  logic                         exeRegWr,
    input  logic                         memFlush,
    // to writeback
    output logic                         memValid,
    output logic [memPkg::dataWidth-1:0] memResult,
    output logic [4:0]                   memDst,
    output logic                         memRegWr,
    output memPkg::excCode               memExc,
    output logic [memPkg::dataWidth-1:0] memBadVAddr,
    // APB master
    output logic [apbAddrWidth-1:0]      paddr,
    output logic                         psel,
    output logic                         penable,
    output logic                         pwrite,
    output logic [memPkg::dataWidth-1:0] pwdata,
    output logic [memPkg::laneCount-1:0] pstrb,
    input  logic [memPkg::dataWidth-1:0] prdata,
    input  logic                         pready,
    input  logic                         pslverr
);
    logic                         heldValid;
    logic [memPkg::dataWidth-1:0] heldAddr;
    logic [memPkg::dataWidth-1:0] heldStoreData;
    memPkg::loadType              heldLoadType;
    memPkg::storeType             heldStoreType;
    logic [4:0]                   heldDst;
    logic                         heldRegWr;
    logic                         retire;
    logic [memPkg::laneCount-1:0] laneStrb;
    logic [memPkg::dataWidth-1:0] laneData;

    memStageReg uMemStageReg (
        .clk           (clk),
        .rstN          (rstN),
        .memFlush      (memFlush),
        .exeValid      (exeValid),
        .exeReady      (exeReady),
        .retire        (retire),
        .exeAluOut     (exeAluOut),
        .exeStoreData  (exeStoreData),
        .exeLoadType   (exeLoadType),
        .exeStoreType  (exeStoreType),
        .exeDst        (exeDst),
        .exeRegWr      (exeRegWr),
        .heldValid     (heldValid),
        .heldAddr      (heldAddr),
        .heldStoreData (heldStoreData),
        .heldLoadType  (heldLoadType),
        .heldStoreType (heldStoreType),
        .heldDst       (heldDst),
        .heldRegWr     (heldRegWr)
    );

    // one alignment unit per byte lane
    for (genvar i = 0; i < memPkg::laneCount; i++) begin : genLane
        storeLane #(
            .laneIndex (i)
        ) uStoreLane (
            .heldStoreType (heldStoreType),
            .addrLow       (heldAddr[1:0]),
            .storeData     (heldStoreData),
            .laneStrb      (laneStrb[i]),
            .laneByte      (laneData[8*i +: 8])
        );
    end

    memAccessCtrl #(
        .apbAddrWidth (apbAddrWidth)
    ) uMemAccessCtrl (
        .clk           (clk),
        .rstN          (rstN),
        .heldValid     (heldValid),
        .heldAddr      (heldAddr),
        .heldLoadType  (heldLoadType),
        .heldStoreType (heldStoreType),
        .heldDst       (heldDst),
        .heldRegWr     (heldRegWr),
        .laneStrb      (laneStrb),
        .laneData      (laneData),
        .retire        (retire),
        .memValid      (memValid),
        .memResult     (memResult),
        .memDst        (memDst),
        .memRegWr      (memRegWr),
        .memExc        (memExc),
        .memBadVAddr   (memBadVAddr),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .pstrb         (pstrb),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr)
    );

endmodule

`default_nettype wire

// File: tests/apbSlaveMem.sv
`timescale 1ns/1ps
`default_nettype none

module apbSlaveMem #(
    parameter int addrWidth = 16
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [2:0]           waitStates,
    input  logic [addrWidth-1:0] errAddr,
    input  logic [addrWidth-1:0] paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [31:0]          pwdata,
    input  logic [3:0]           pstrb,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic [31:0]          xferCount
);
    logic [31:0] mem [64];
    logic [2:0]  waitCnt;    // access cycles spent so far
    logic        access;
    logic [5:0]  wordIdx;

    assign access  = psel && penable;
    assign wordIdx = paddr[7:2];
    assign pready  = access && (waitCnt >= waitStates);
    assign pslverr = pready && (paddr == errAddr);
    assign prdata  = mem[wordIdx];

    // every byte of the fill depends on the full word index
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = {8'(i) ^ 8'h96, 8'(i * 5 + 3), 8'(~i), 8'(i * 37)};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            waitCnt   <= '0;
            xferCount <= '0;
        end else begin
            waitCnt <= (access && !pready) ? waitCnt + 3'd1 : 3'd0;
            if (pready) begin
                xferCount <= xferCount + 32'd1;
            end
        end
    end

    // erroring accesses leave the array alone
    always @(posedge clk) begin
        if (pready && pwrite && !pslverr) begin
            if (pstrb[0]) mem[wordIdx][7:0]   <= pwdata[7:0];
            if (pstrb[1]) mem[wordIdx][15:8]  <= pwdata[15:8];
            if (pstrb[2]) mem[wordIdx][23:16] <= pwdata[23:16];
            if (pstrb[3]) mem[wordIdx][31:24] <= pwdata[31:24];
        end
    end

endmodule

`default_nettype wire

// File: tests/memStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module memStageTb;
    localparam int apbAddrWidth = 16;
    localparam int numInstr     = 400;
    localparam int maxWait      = 5;
    localparam int cycleLimit   = 20 + numInstr * (maxWait + 4);
    localparam logic [5:0] errWord = 6'd45;     // slave answers this word with pslverr

    typedef struct packed {
        logic                         busAccess;
        logic                         isStore;
        logic                         checkResult;
        logic [memPkg::dataWidth-1:0] result;
        logic [memPkg::dataWidth-1:0] addr;
        logic [4:0]                   dst;
        logic                         regWr;
        memPkg::excCode               exc;
        logic [memPkg::laneCount-1:0] strb;
    } expEntry;

    logic                         clk = 1'b0;
    logic                         rstN;
    logic                         exeValid;
    logic                         exeReady;
    logic [memPkg::dataWidth-1:0] exeAluOut;
    logic [memPkg::dataWidth-1:0] exeStoreData;
    memPkg::loadType              exeLoadType;
    memPkg::storeType             exeStoreType;
    logic [4:0]                   exeDst;
    logic                         exeRegWr;
    logic                         memFlush;
    logic                         memValid;
    logic [memPkg::dataWidth-1:0] memResult;
    logic [4:0]                   memDst;
    logic                         memRegWr;
    memPkg::excCode               memExc;
    logic [memPkg::dataWidth-1:0] memBadVAddr;
    logic [apbAddrWidth-1:0]      paddr;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [memPkg::dataWidth-1:0] pwdata;
    logic [memPkg::laneCount-1:0] pstrb;
    logic [memPkg::dataWidth-1:0] prdata;
    logic                         pready;
    logic                         pslverr;
    logic [2:0]                   waitStates;
    logic [31:0]                  xferCount;

    logic [31:0]                  lfsr;
    logic [31:0]                  refMem [64];
    expEntry                      expQ [$];     // outstanding retirements, oldest first
    expEntry                      pending;
    int                           xferExp = 0;
    int                           cycles = 0;

    memStage #(
        .apbAddrWidth (apbAddrWidth)
    ) dut (
        .clk          (clk),
        .rstN         (rstN),
        .exeValid     (exeValid),
        .exeReady     (exeReady),
        .exeAluOut    (exeAluOut),
        .exeStoreData (exeStoreData),
        .exeLoadType  (exeLoadType),
        .exeStoreType (exeStoreType),
        .exeDst       (exeDst),
        .exeRegWr     (exeRegWr),
        .memFlush     (memFlush),
        .memValid     (memValid),
        .memResult    (memResult),
        .memDst       (memDst),
        .memRegWr     (memRegWr),
        .memExc       (memExc),
        .memBadVAddr  (memBadVAddr),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .pstrb        (pstrb),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr)
    );

    apbSlaveMem #(
        .addrWidth (apbAddrWidth)
    ) slave (
        .clk        (clk),
        .rstN       (rstN),
        .waitStates (waitStates),
        .errAddr    (apbAddrWidth'({errWord, 2'b00})),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .xferCount  (xferCount)
    );

    always #20 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic lfsrStep();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsrStep()};
        end
        return v;
    endfunction

    task automatic stopOnFailure();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkWord(input string name, input logic [memPkg::dataWidth-1:0] exp,
                             input logic [memPkg::dataWidth-1:0] got);
        if (exp !== got) begin
            $display("error at %0t: %s expected %h, got %h", $time, name, exp, got);
            stopOnFailure();
        end
    endtask

    task automatic checkDst(input logic [4:0] expDst, input logic expWr,
                            input logic [4:0] gotDst, input logic gotWr);
        if (expDst !== gotDst) begin
            $display("error at %0t: memDst expected %0d, got %0d", $time, expDst, gotDst);
            stopOnFailure();
        end
        if (expWr !== gotWr) begin
            $display("error at %0t: memRegWr expected %b, got %b", $time, expWr, gotWr);
            stopOnFailure();
        end
    endtask

    task automatic checkExc(input memPkg::excCode exp, input memPkg::excCode got);
        if (exp !== got) begin
            $display("error at %0t: memExc expected %0d, got %0d", $time, exp, got);
            stopOnFailure();
        end
    endtask

    task automatic checkStrb(input logic [memPkg::laneCount-1:0] exp,
                             input logic [memPkg::laneCount-1:0] got);
        if (exp !== got) begin
            $display("error at %0t: pstrb expected %b, got %b", $time, exp, got);
            stopOnFailure();
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic got);
        if (exp !== got) begin
            $display("error at %0t: %s expected %b, got %b", $time, name, exp, got);
            stopOnFailure();
        end
    endtask

    task automatic checkIdleOutputs();
        checkBit("psel", 1'b0, psel);
        checkBit("penable", 1'b0, penable);
        checkBit("memValid", 1'b0, memValid);
        checkBit("exeReady", 1'b1, exeReady);
    endtask

    // drives one random instruction and works out its retirement from the lane and extension rules
    task automatic makeInstr(output expEntry e);
        logic [2:0]                   kind;
        logic [5:0]                   word;
        logic [1:0]                   off;
        logic                         skew;
        logic                         isLoad;
        logic                         misaligned;
        logic                         wr;
        int                           size;
        logic [memPkg::dataWidth-1:0] w;
        logic [memPkg::dataWidth-1:0] placed;
        logic [7:0]                   b8;
        logic [15:0]                  h16;

        e            = '0;
        e.exc        = memPkg::excNone;
        kind         = 3'(randBits(3));
        e.dst        = 5'(randBits(5));
        wr           = randBits(2) != 32'd0;
        exeDst       = e.dst;
        exeRegWr     = wr;
        exeStoreData = randBits(32);
        exeLoadType  = memPkg::ldNone;
        exeStoreType = memPkg::stNone;
        if (kind < 3'd2) begin
            exeAluOut     = randBits(32);   // ALU result passes through
            e.checkResult = 1'b1;
            e.result      = exeAluOut;
            e.regWr       = wr;
        end else begin
            isLoad = kind < 3'd5;
            word   = (randBits(4) == 32'd0) ? errWord : 6'(randBits(6));
            off    = 2'(randBits(2));
            skew   = randBits(3) == 32'd0;  // about one in eight misaligned
            if (isLoad) begin
                case (3'(randBits(3)))
                    3'd0:    exeLoadType = memPkg::ldByte;
                    3'd1:    exeLoadType = memPkg::ldByteU;
                    3'd2:    exeLoadType = memPkg::ldHalf;
                    3'd3:    exeLoadType = memPkg::ldHalfU;
                    default: exeLoadType = memPkg::ldWord;
                endcase
            end else begin
                case (2'(randBits(2)))
                    2'd0:    exeStoreType = memPkg::stByte;
                    2'd1:    exeStoreType = memPkg::stHalf;
                    default: exeStoreType = memPkg::stWord;
                endcase
            end
            size = 4;
            if (exeLoadType inside {memPkg::ldHalf, memPkg::ldHalfU} ||
                    exeStoreType == memPkg::stHalf) begin
                size = 2;
            end else if (exeLoadType inside {memPkg::ldByte, memPkg::ldByteU} ||
                    exeStoreType == memPkg::stByte) begin
                size = 1;
            end
            if (size == 2) begin
                off[0] = skew;
            end else if (size == 4) begin
                off = !skew ? 2'd0 : (off == 2'd0) ? 2'd2 : off;
            end
            misaligned = (size == 2 && off[0]) || (size == 4 && off != 2'd0);
            e.addr     = {24'h0, word, off};
            exeAluOut  = e.addr;
            w          = refMem[word];
            if (misaligned) begin
                e.exc = isLoad ? memPkg::excAdEL : memPkg::excAdES;
            end else begin
                e.busAccess = 1'b1;
                e.isStore   = !isLoad;
                xferExp++;
                case (exeStoreType)
                    memPkg::stByte: begin
                        e.strb = 4'b0001 << off;
                        placed = {4{exeStoreData[7:0]}};
                    end
                    memPkg::stHalf: begin
                        e.strb = off[1] ? 4'b1100 : 4'b0011;
                        placed = {2{exeStoreData[15:0]}};
                    end
                    default: begin
                        e.strb = 4'b1111;
                        placed = exeStoreData;
                    end
                endcase
                if (word == errWord) begin
                    e.exc = memPkg::excDBE;
                end else if (isLoad) begin
                    e.regWr       = wr;
                    e.checkResult = 1'b1;
                    b8            = w[{off, 3'b000} +: 8];
                    h16           = w[{off[1], 4'b0000} +: 16];
                    case (exeLoadType)
                        memPkg::ldByte:  e.result = {{24{b8[7]}}, b8};
                        memPkg::ldByteU: e.result = {24'h0, b8};
                        memPkg::ldHalf:  e.result = {{16{h16[15]}}, h16};
                        memPkg::ldHalfU: e.result = {16'h0, h16};
                        default:         e.result = w;
                    endcase
                end else begin
                    e.regWr = wr;
                    for (int k = 0; k < 4; k++) begin
                        if (e.strb[k]) begin
                            refMem[word][8*k +: 8] = placed[8*k +: 8];
                        end
                    end
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (rstN) begin
            cycles = cycles + 1;
            if (cycles > cycleLimit) begin
                $display("timeout: the stage stopped retiring within %0d cycles", cycleLimit);
                stopOnFailure();
            end
        end
    end

    // bus phases and retirements, sampled mid-cycle
    always @(negedge clk) begin : monitor
        expEntry e;
        if (rstN) begin
            if (psel) begin
                if (expQ.size() == 0 || !expQ[0].busAccess) begin
                    $display("an APB transfer started for an instruction that needs no bus access");
                    stopOnFailure();
                end else if (penable) begin
                    e = expQ[0];
                    checkBit("pwrite", e.isStore, pwrite);
                    checkWord("paddr", {e.addr[31:2], 2'b00}, 32'(paddr));
                    if (e.isStore) begin
                        checkStrb(e.strb, pstrb);
                    end
                end
            end
            if (memValid) begin
                if (expQ.size() == 0) begin
                    $display("memValid rose with no instruction outstanding");
                    stopOnFailure();
                end else begin
                    e = expQ.pop_front();
                    checkExc(e.exc, memExc);
                    checkDst(e.dst, e.regWr, memDst, memRegWr);
                    if (e.checkResult) begin
                        checkWord("memResult", e.result, memResult);
                    end
                    if (e.exc == memPkg::excAdEL || e.exc == memPkg::excAdES) begin
                        checkWord("memBadVAddr", e.addr, memBadVAddr);
                    end
                end
            end
        end
    end

    initial begin
        lfsr         = 32'hd1eb_2049;
        rstN         = 1'b0;
        exeValid     = 1'b0;
        exeAluOut    = '0;
        exeStoreData = '0;
        exeLoadType  = memPkg::ldNone;
        exeStoreType = memPkg::stNone;
        exeDst       = '0;
        exeRegWr     = 1'b0;
        memFlush     = 1'b0;
        waitStates   = '0;
        repeat (8) begin
            @(negedge clk);
            checkIdleOutputs();
        end
        rstN = 1'b1;
        @(negedge clk);
        checkIdleOutputs();
        for (int i = 0; i < 64; i++) begin
            refMem[i] = slave.mem[i];
        end

        for (int n = 0; n < numInstr; n++) begin
            if (randBits(3) == 32'd0) begin     // occasional bubble
                exeValid = 1'b0;
                @(negedge clk);
            end
            makeInstr(pending);
            exeValid = 1'b1;
            while (!exeReady) begin
                @(negedge clk);
            end
            expQ.push_back(pending);    // taken at the coming rising edge
            @(negedge clk);
            waitStates = 3'(randBits(3) % 32'd6);
        end
        exeValid = 1'b0;

        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);      // room for a stray extra retirement
        checkWord("xferCount", 32'(xferExp), xferCount);
        for (int i = 0; i < 64; i++) begin
            checkWord($sformatf("mem[%0d]", i), refMem[i], slave.mem[i]);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
design/memPkg.sv
design/memStageReg.sv
design/storeLane.sv
design/memAccessCtrl.sv
design/memStage.sv
tests/apbSlaveMem.sv
tests/memStageTb.sv

// File: run.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module memStageTb -o memStageSim

./obj_dir/memStageSim > sim.log 2>&1 || true
cat sim.log

if grep -q '>>> FAIL' sim.log || ! grep -q '>>> PASS' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
